// ==== hdl/cache_pkg.sv ====
package cache_pkg;

	// sizes, all addresses are word addresses
	localparam int ADDR_BITS      = 32;
	localparam int WORD_BITS      = 32;
	localparam int WORDS_PER_LINE = 4;
	localparam int OFFSET_BITS    = 2;
	localparam int SET_BITS       = 6;                                  // 64 sets
	localparam int TAG_BITS       = ADDR_BITS - SET_BITS - OFFSET_BITS; // 24

	typedef logic [WORD_BITS-1:0] word_t;

	// word 0 sits in the low bits
	typedef word_t [WORDS_PER_LINE-1:0] line_t;

	typedef struct packed {
		logic                valid;
		logic                used;  // set on the most recent access in the set
		logic                dirty;
		logic [TAG_BITS-1:0] tag;
	} tag_entry_t;

	typedef struct packed {
		logic [TAG_BITS-1:0]    tag;
		logic [SET_BITS-1:0]    index;
		logic [OFFSET_BITS-1:0] offset;
	} addr_fields_t;

	typedef struct packed {
		logic                 read;
		logic                 write;
		logic [ADDR_BITS-1:0] addr;
		word_t                wdata;
	} cpu_req_t;

	typedef struct packed {
		logic                 read;
		logic                 write;
		logic [ADDR_BITS-1:0] addr;  // line aligned
		word_t                wdata;
	} mem_req_t;

	typedef struct packed {
		logic                hit;
		logic                hit_way;
		logic                victim_way;
		logic                victim_dirty;
		logic [TAG_BITS-1:0] victim_tag;
		word_t               hit_word;
	} lookup_t;

endpackage

// ==== hdl/way_store.sv ====
`timescale 1ns/1ps

module way_store #(
	parameter type entry_t = logic
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [cache_pkg::SET_BITS-1:0] index,
	input  logic                          wr_en,
	input  entry_t                        wr_data,
	output entry_t                        rd_data
);

	localparam int SETS = 1 << cache_pkg::SET_BITS;

	entry_t mem [SETS];

	assign rd_data = mem[index]; // read is combinational

	// clearing every entry drops all valid bits
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < SETS; i++) begin
				mem[i] <= '0;
			end
		end else if (wr_en) begin
			mem[index] <= wr_data;
		end
	end

endmodule

// ==== hdl/hit_detect.sv ====
`timescale 1ns/1ps

module hit_detect (
	input  logic [cache_pkg::TAG_BITS-1:0]    req_tag,
	input  logic [cache_pkg::OFFSET_BITS-1:0] offset,
	input  cache_pkg::tag_entry_t             tag_0,
	input  cache_pkg::tag_entry_t             tag_1,
	input  cache_pkg::line_t                  line_0,
	input  cache_pkg::line_t                  line_1,
	output cache_pkg::lookup_t                result
);

	logic             hit_0;
	logic             hit_1;
	logic             victim;
	cache_pkg::line_t hit_line;

	// a tag only counts when its line is valid
	assign hit_0 = tag_0.valid && (tag_0.tag == req_tag);
	assign hit_1 = tag_1.valid && (tag_1.tag == req_tag);

	assign hit_line = hit_1 ? line_1 : line_0;

	// replacement choice
	always_comb begin
		if (!tag_0.valid) begin
			victim = 1'b0;
		end else if (!tag_1.valid) begin
			victim = 1'b1;
		end else if (!tag_0.used) begin
			victim = 1'b0;
		end else begin
			victim = 1'b1;
		end
	end

	always_comb begin
		result.hit          = hit_0 || hit_1;
		result.hit_way      = hit_1;          // both ways never hold the same tag
		result.victim_way   = victim;
		result.victim_dirty = victim ? tag_1.dirty : tag_0.dirty;
		result.victim_tag   = victim ? tag_1.tag : tag_0.tag;
		result.hit_word     = hit_line[offset];
	end

endmodule

// ==== hdl/line_transfer.sv ====
`timescale 1ns/1ps

module line_transfer (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start_fill,
	input  logic                    start_evict,
	input  cache_pkg::addr_fields_t line_addr,
	input  cache_pkg::line_t        evict_line,
	output cache_pkg::mem_req_t     mem_req,
	input  cache_pkg::word_t        rdata_mem,
	input  logic                    ready_mem,
	output cache_pkg::line_t        fill_line,
	output logic                    xfer_done
);

	logic                                rd_active;
	logic                                wr_active;
	logic [cache_pkg::OFFSET_BITS-1:0]   count;      // words moved so far
	logic [cache_pkg::ADDR_BITS-1:0]     burst_addr;
	cache_pkg::line_t                    shift;
	logic                                beat;

	// one word crosses the bus on this edge
	assign beat = (rd_active || wr_active) && ready_mem;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rd_active <= 1'b0;
			wr_active <= 1'b0;
			count     <= '0;
			xfer_done <= 1'b0;
		end else begin
			xfer_done <= 1'b0;
			if (start_fill) begin
				rd_active <= 1'b1;
				count     <= '0;
			end else if (start_evict) begin
				wr_active <= 1'b1;
				count     <= '0;
			end else if (beat) begin
				count <= count + 1'b1;
				if (count == '1) begin // fourth word, level drops now
					rd_active <= 1'b0;
					wr_active <= 1'b0;
					xfer_done <= 1'b1;
				end
			end
		end
	end

	// address and line shift register
	always_ff @(posedge clk) begin
		if (start_fill || start_evict) begin
			burst_addr <= {line_addr.tag, line_addr.index, {cache_pkg::OFFSET_BITS{1'b0}}};
		end
		if (start_evict) begin
			shift <= evict_line;
		end else if (beat) begin
			// fill shifts new words in at the top; eviction rotates the line out
			shift <= {(rd_active ? rdata_mem : shift[0]),
				shift[cache_pkg::WORDS_PER_LINE-1:1]};
		end
	end

	always_comb begin
		mem_req.read  = rd_active;
		mem_req.write = wr_active;
		mem_req.addr  = burst_addr;
		mem_req.wdata = shift[0];   // current outgoing word
	end

	assign fill_line = shift;

endmodule

// ==== hdl/cache_fsm.sv ====
`timescale 1ns/1ps

module cache_fsm (
	input  logic                           clk,
	input  logic                           reset,
	input  cache_pkg::cpu_req_t            cpu_req,
	input  cache_pkg::lookup_t             result,
	input  cache_pkg::tag_entry_t          tag_0,
	input  cache_pkg::tag_entry_t          tag_1,
	input  cache_pkg::line_t               line_0,
	input  cache_pkg::line_t               line_1,
	input  cache_pkg::line_t               fill_line,
	input  logic                           xfer_done,
	output logic [cache_pkg::SET_BITS-1:0] index,
	output logic                           tag_wr_en_0,
	output logic                           tag_wr_en_1,
	output cache_pkg::tag_entry_t [1:0]    tag_wr,
	output logic                           data_wr_en_0,
	output logic                           data_wr_en_1,
	output cache_pkg::line_t               data_wr,
	output logic                           start_fill,
	output logic                           start_evict,
	output cache_pkg::addr_fields_t        line_addr,
	output cache_pkg::line_t               evict_line,
	output cache_pkg::word_t               rd_data,
	output logic                           stall_up
);

	typedef enum logic [2:0] {
		idle,
		lookup,
		evict,
		fill,
		install
	} state_t;

	state_t                          state;
	cache_pkg::addr_fields_t         req;
	cache_pkg::word_t                wdata;
	logic                            is_write;
	logic                            was_hit;
	logic                            way;       // hit way or the victim on a miss
	logic [cache_pkg::TAG_BITS-1:0]  vic_tag;
	cache_pkg::line_t                base_line;
	cache_pkg::line_t                merged;
	cache_pkg::tag_entry_t           own_tag;
	cache_pkg::tag_entry_t           other_tag;
	cache_pkg::tag_entry_t           own_new;
	cache_pkg::tag_entry_t           other_new;
	logic                            new_req;

	assign new_req = cpu_req.read || cpu_req.write;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state       <= idle;
			stall_up    <= 1'b0;
			start_fill  <= 1'b0;
			start_evict <= 1'b0;
		end else begin
			start_fill  <= 1'b0; // one cycle strobes
			start_evict <= 1'b0;
			case (state)
				idle: begin
					if (new_req) begin
						stall_up <= 1'b1;
						state    <= lookup;
					end
				end
				lookup: begin
					if (result.hit) begin
						state <= install;
					end else if (result.victim_dirty) begin
						start_evict <= 1'b1;
						state       <= evict;
					end else begin
						start_fill <= 1'b1;
						state      <= fill;
					end
				end
				evict: begin
					if (xfer_done) begin  // victim written back so fetch the new line
						start_fill <= 1'b1;
						state      <= fill;
					end
				end
				fill: begin
					if (xfer_done) begin
						state <= install;
					end
				end
				install: begin
					stall_up <= 1'b0;
					state    <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// request and lookup capture
	always_ff @(posedge clk) begin
		if (state == idle && new_req) begin
			req      <= cpu_req.addr;
			wdata    <= cpu_req.wdata;
			is_write <= cpu_req.write;
		end
		if (state == lookup) begin
			was_hit <= result.hit;
			way     <= result.hit ? result.hit_way : result.victim_way;
			vic_tag <= result.victim_tag;
			if (result.hit) begin
				rd_data <= result.hit_word;
			end
		end
		if (state == install && !was_hit) begin
			rd_data <= merged[req.offset]; // word from the freshly filled line
		end
	end

	// line to install with the write word merged in
	always_comb begin
		base_line = was_hit ? (way ? line_1 : line_0) : fill_line;
		merged    = base_line;
		if (is_write) begin
			merged[req.offset] = wdata;
		end
	end

	// accessed way becomes most recent and the other loses its used bit
	always_comb begin
		own_tag   = way ? tag_1 : tag_0;
		other_tag = way ? tag_0 : tag_1;

		own_new.valid = 1'b1;
		own_new.used  = 1'b1;
		own_new.dirty = (was_hit && own_tag.dirty) || is_write;
		own_new.tag   = req.tag;

		other_new      = other_tag;
		other_new.used = 1'b0;

		tag_wr[0] = way ? other_new : own_new;
		tag_wr[1] = way ? own_new : other_new;
	end

	assign tag_wr_en_0 = (state == install);
	assign tag_wr_en_1 = (state == install);

	// a read hit leaves the line untouched
	assign data_wr_en_0 = (state == install) && !way && (is_write || !was_hit);
	assign data_wr_en_1 = (state == install) && way && (is_write || !was_hit);
	assign data_wr      = merged;

	assign index = req.index;

	always_comb begin
		line_addr = req;
		if (state == evict) begin
			line_addr.tag = vic_tag; // write-back goes to the victim's line
		end
	end

	assign evict_line = way ? line_1 : line_0;

endmodule

// ==== hdl/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                clk,
	input  logic                reset,
	input  cache_pkg::cpu_req_t cpu_req,
	output cache_pkg::word_t    rd_data,
	output logic                stall_up,
	output cache_pkg::mem_req_t mem_req,
	input  cache_pkg::word_t    rdata_mem,
	input  logic                ready_mem
);

	logic [cache_pkg::SET_BITS-1:0] index;
	logic                           tag_wr_en_0;
	logic                           tag_wr_en_1;
	cache_pkg::tag_entry_t [1:0]    tag_wr;
	logic                           data_wr_en_0;
	logic                           data_wr_en_1;
	cache_pkg::line_t               data_wr;
	cache_pkg::tag_entry_t          tag_0;
	cache_pkg::tag_entry_t          tag_1;
	cache_pkg::line_t               line_0;
	cache_pkg::line_t               line_1;
	cache_pkg::lookup_t             result;
	logic                           start_fill;
	logic                           start_evict;
	cache_pkg::addr_fields_t        line_addr;  // request line, or victim line during write-back
	cache_pkg::line_t               evict_line;
	cache_pkg::line_t               fill_line;
	logic                           xfer_done;

	way_store #(.entry_t(cache_pkg::tag_entry_t)) tag_store_0 (
		.clk(clk), .reset(reset), .index(index),
		.wr_en(tag_wr_en_0), .wr_data(tag_wr[0]), .rd_data(tag_0)
	);

	way_store #(.entry_t(cache_pkg::tag_entry_t)) tag_store_1 (
		.clk(clk), .reset(reset), .index(index),
		.wr_en(tag_wr_en_1), .wr_data(tag_wr[1]), .rd_data(tag_1)
	);

	way_store #(.entry_t(cache_pkg::line_t)) data_store_0 (
		.clk(clk), .reset(reset), .index(index),
		.wr_en(data_wr_en_0), .wr_data(data_wr), .rd_data(line_0)
	);

	way_store #(.entry_t(cache_pkg::line_t)) data_store_1 (
		.clk(clk), .reset(reset), .index(index),
		.wr_en(data_wr_en_1), .wr_data(data_wr), .rd_data(line_1)
	);

	hit_detect u_hit_detect (
		.req_tag(line_addr.tag), .offset(line_addr.offset),
		.tag_0(tag_0), .tag_1(tag_1), .line_0(line_0), .line_1(line_1),
		.result(result)
	);

	cache_fsm u_cache_fsm (
		.clk(clk), .reset(reset), .cpu_req(cpu_req), .result(result),
		.tag_0(tag_0), .tag_1(tag_1), .line_0(line_0), .line_1(line_1),
		.fill_line(fill_line), .xfer_done(xfer_done), .index(index),
		.tag_wr_en_0(tag_wr_en_0), .tag_wr_en_1(tag_wr_en_1), .tag_wr(tag_wr),
		.data_wr_en_0(data_wr_en_0), .data_wr_en_1(data_wr_en_1), .data_wr(data_wr),
		.start_fill(start_fill), .start_evict(start_evict), .line_addr(line_addr),
		.evict_line(evict_line), .rd_data(rd_data), .stall_up(stall_up)
	);

	line_transfer u_line_transfer (
		.clk(clk), .reset(reset), .start_fill(start_fill), .start_evict(start_evict),
		.line_addr(line_addr), .evict_line(evict_line), .mem_req(mem_req),
		.rdata_mem(rdata_mem), .ready_mem(ready_mem),
		.fill_line(fill_line), .xfer_done(xfer_done)
	);

endmodule

// ==== tb/tb_main_mem.sv ====
`timescale 1ns/1ps

module tb_main_mem #(
	parameter logic [31:0] fill_key = 32'h0
) (
	input  logic                clk,
	input  logic                reset,
	input  cache_pkg::mem_req_t mem_req,
	output cache_pkg::word_t    rdata_mem,
	output logic                ready_mem
);

	cache_pkg::word_t  store [logic [31:0]];  // only words written so far
	logic [1:0]        beat;                  // offset of the next word in the burst
	cache_pkg::line_t  wr_line;
	logic [31:0]       wr_addr_q [$];         // one entry per finished write burst
	cache_pkg::line_t  wr_line_q [$];

	function automatic cache_pkg::word_t peek(input logic [31:0] addr);
		if (store.exists(addr)) begin
			return store[addr];
		end
		return addr ^ fill_key; // untouched word
	endfunction

	initial begin
		ready_mem = 1'b0;
		rdata_mem = '0;
		beat      = '0;
	end

	// a beat decided here is consumed on the next rising edge
	always @(negedge clk) begin
		if (!reset) begin
			ready_mem = 1'b0;
			beat      = '0;
		end else begin
			ready_mem = ($urandom_range(3, 0) != 0); // low about a quarter of the time
			if (ready_mem && (mem_req.read || mem_req.write)) begin
				if (mem_req.read) begin
					rdata_mem = peek(mem_req.addr + beat);
				end else begin
					store[mem_req.addr + beat] = mem_req.wdata;
					wr_line[beat] = mem_req.wdata;
					if (beat == 2'd3) begin
						wr_addr_q.push_back(mem_req.addr);
						wr_line_q.push_back(wr_line);
					end
				end
				beat = beat + 1'b1;
			end
		end
	end

endmodule

// ==== tb/cache_ctrl_sva.sv ====
`timescale 1ns/1ps

module cache_ctrl_sva (
	input logic                clk,
	input logic                reset,
	input cache_pkg::mem_req_t mem_req,
	input logic                stall_up
);

	logic active;

	assign active = mem_req.read || mem_req.write; // a burst is running

	one_direction: assert property (@(posedge clk) disable iff (!reset)
		!(mem_req.read && mem_req.write))
		else $error("memory read and write are high together");

	addr_stable: assert property (@(posedge clk) disable iff (!reset)
		(active && $past(active)) |-> $stable(mem_req.addr))
		else $error("burst address changed inside a burst");

	// processor must wait while the memory bus is busy
	stall_in_burst: assert property (@(posedge clk) disable iff (!reset)
		active |-> stall_up)
		else $error("stall_up low during a burst");

endmodule

bind cache_ctrl cache_ctrl_sva bus_checks (
	.clk(clk), .reset(reset), .mem_req(mem_req), .stall_up(stall_up)
);

// ==== tb/tb_cache_ctrl.sv ====
`timescale 1ns/1ps

module tb_cache_ctrl;

	localparam logic [31:0] fill_key     = 32'h5a3c_96e1;
	localparam int          access_limit = 400;  // cycles per request

	logic                clk;
	logic                reset;
	cache_pkg::cpu_req_t cpu_req;
	cache_pkg::word_t    rd_data;
	logic                stall_up;
	cache_pkg::mem_req_t mem_req;
	cache_pkg::word_t    rdata_mem;
	logic                ready_mem;

	cache_pkg::word_t ref_mem [logic [31:0]]; // reference word memory
	int               error_count  = 0;
	int               test_errors  = 0;
	int               tests_run    = 0;
	int               tests_failed = 0;

	cache_ctrl DUT (
		.clk(clk), .reset(reset), .cpu_req(cpu_req), .rd_data(rd_data), .stall_up(stall_up),
		.mem_req(mem_req), .rdata_mem(rdata_mem), .ready_mem(ready_mem)
	);

	tb_main_mem #(.fill_key(fill_key)) main_mem (
		.clk(clk), .reset(reset), .mem_req(mem_req), .rdata_mem(rdata_mem), .ready_mem(ready_mem)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic cache_pkg::word_t ref_read(input logic [31:0] addr);
		if (ref_mem.exists(addr)) begin
			return ref_mem[addr];
		end
		return addr ^ fill_key;
	endfunction

	function automatic logic [31:0] make_addr(input logic [cache_pkg::TAG_BITS-1:0] tag,
		input logic [cache_pkg::SET_BITS-1:0] index, input logic [1:0] offset);
		cache_pkg::addr_fields_t f;
		f.tag    = tag;
		f.index  = index;
		f.offset = offset;
		return f;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		error_count++;
		test_errors++;
	endtask

	task automatic abort_run(input string what);
		$display("timeout: %s", what);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	// one request, called and left on a falling edge
	task automatic run_access(input string name, input bit wr, input logic [31:0] addr,
		input cache_pkg::word_t data, output cache_pkg::word_t rdata, output int cycles);
		cpu_req.read  = !wr;
		cpu_req.write = wr;
		cpu_req.addr  = addr;
		cpu_req.wdata = data;
		@(negedge clk);
		cpu_req.read  = 1'b0;
		cpu_req.write = 1'b0;
		if (!stall_up) begin
			$display("%s: stall_up did not rise after the request", name);
			error_count++;
			test_errors++;
		end
		cycles = 0;
		while (stall_up && cycles < access_limit) begin
			cycles++;
			@(negedge clk);
		end
		if (stall_up) begin
			abort_run($sformatf("%s: stall_up stayed high", name));
		end else begin
			rdata = rd_data;
			if (wr) begin
				ref_mem[addr] = data;
			end
		end
	endtask

	initial begin
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      c;
		cache_pkg::word_t got;
		cache_pkg::word_t wdat;
		cache_pkg::word_t b_data;
		int               cycles;
		int               n;

		void'($urandom(89));
		reset   = 1'b0;
		cpu_req = '0;
		repeat (16) @(negedge clk);
		reset = 1'b1;
		@(negedge clk);

		if (stall_up !== 1'b0) report_mismatch("reset_idle stall_up", 0, stall_up);
		if (mem_req.read !== 1'b0) report_mismatch("reset_idle mem read", 0, mem_req.read);
		if (mem_req.write !== 1'b0) report_mismatch("reset_idle mem write", 0, mem_req.write);
		finish_test("reset_idle");

		a = make_addr(24'h10, 6'd5, 2'd2);
		run_access("read_miss_fill", 1'b0, a, '0, got, cycles);
		if (got !== ref_read(a)) report_mismatch("read_miss_fill miss", ref_read(a), got);
		run_access("read_miss_fill", 1'b0, a, '0, got, cycles);
		if (got !== ref_read(a)) report_mismatch("read_miss_fill hit", ref_read(a), got);
		if (cycles != 2) report_mismatch("read_miss_fill hit latency", 2, cycles);
		finish_test("read_miss_fill");

		wdat = $urandom;
		run_access("write_hit_readback", 1'b1, a, wdat, got, cycles);
		run_access("write_hit_readback", 1'b0, a, '0, got, cycles);
		if (got !== wdat) report_mismatch("write_hit_readback", wdat, got);
		finish_test("write_hit_readback");

		// three tags in set 9, B ends up as the dirty victim
		a      = make_addr(24'h20, 6'd9, 2'd1);
		b      = make_addr(24'h21, 6'd9, 2'd3);
		c      = make_addr(24'h22, 6'd9, 2'd0);
		wdat   = $urandom;
		b_data = $urandom;
		run_access("dirty_eviction", 1'b1, a, wdat, got, cycles);
		run_access("dirty_eviction", 1'b1, b, b_data, got, cycles);
		run_access("dirty_eviction", 1'b0, a, '0, got, cycles);
		if (got !== wdat) report_mismatch("dirty_eviction read A", wdat, got);
		n = main_mem.wr_addr_q.size();
		run_access("dirty_eviction", 1'b0, c, '0, got, cycles);
		if (got !== ref_read(c)) report_mismatch("dirty_eviction read C", ref_read(c), got);
		if (main_mem.wr_addr_q.size() <= n) begin
			$display("dirty_eviction: no write burst for the dirty victim");
			error_count++;
			test_errors++;
		end else begin
			if (main_mem.wr_addr_q[n] !== (b & 32'hffff_fffc))
				report_mismatch("dirty_eviction burst addr", b & 32'hffff_fffc,
					main_mem.wr_addr_q[n]);
			if (main_mem.wr_line_q[n][3] !== b_data)
				report_mismatch("dirty_eviction burst word", b_data, main_mem.wr_line_q[n][3]);
		end
		finish_test("dirty_eviction");

		// four tags over two sets keep both ways busy
		for (int i = 0; i < 300; i++) begin
			a = make_addr($urandom_range(24'h43, 24'h40), $urandom_range(21, 20),
				$urandom_range(3, 0));
			if ($urandom_range(1, 0) == 1) begin
				wdat = $urandom;
				run_access("random_mix", 1'b1, a, wdat, got, cycles);
			end else begin
				run_access("random_mix", 1'b0, a, '0, got, cycles);
				if (got !== ref_read(a))
					report_mismatch($sformatf("random_mix op %0d", i), ref_read(a), got);
			end
		end
		finish_test("random_mix");

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== cache_ctrl.f ====
hdl/cache_pkg.sv
hdl/way_store.sv
hdl/hit_detect.sv
hdl/line_transfer.sv
hdl/cache_fsm.sv
hdl/cache_ctrl.sv
tb/tb_main_mem.sv
tb/cache_ctrl_sva.sv
tb/tb_cache_ctrl.sv
